// File: rtl/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Width of data values and addresses.
`define EXEC_XLEN 32

// Every instruction is a full word, so the sequential pc moves by this many bytes.
`define EXEC_ILEN_BYTES 4

`endif

// File: rtl/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;

  // Compare operations return their outcome in bit 0.
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_t;

  typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_CSR} op2_sel_t;

  typedef enum logic [2:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH, NPC_CSR} npc_sel_t;

  typedef enum logic [1:0] {WB_ALU, WB_SNPC, WB_DNPC, WB_CSR} wb_sel_t;

  typedef struct packed {
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    word_t    csr_val;
    alu_op_t  alu_op;
    op2_sel_t op2_sel;
    npc_sel_t npc_sel;
    wb_sel_t  wb_sel;
  } issue_t;

  typedef struct packed {
    alu_op_t  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    word_t    snpc;
    word_t    dnpc;
    word_t    csr_val;
    npc_sel_t npc_sel;
    wb_sel_t  wb_sel;
    word_t    store_data;
  } operand_t;

  typedef struct packed {
    word_t wb_data;
    word_t npc;
    logic  redirect;
    word_t store_data;
  } result_t;

endpackage

// File: rtl/exec_if.sv
`timescale 1ns/1ps

// One link only uses the payload field that matches its traffic.
interface exec_if;
  import exec_pkg::*;

  logic     valid;
  logic     ready;
  operand_t operand;
  result_t  result;

  modport source (
    output valid,
    output operand,
    output result,
    input  ready
  );

  modport sink (
    input  valid,
    input  operand,
    input  result,
    output ready
  );

endinterface

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu (
  input  exec_pkg::alu_op_t     op,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  output logic [`EXEC_XLEN-1:0] result
);
  import exec_pkg::*;

  localparam int SHIFT_W = $clog2(`EXEC_XLEN);

  logic [SHIFT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               equal;

  assign shamt       = b[SHIFT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal       = a == b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_SLT:  result = `EXEC_XLEN'(lt_signed);
      ALU_SLTU: result = `EXEC_XLEN'(lt_unsigned);
      ALU_EQ:   result = `EXEC_XLEN'(equal); // Branch compares from here down.
      ALU_NE:   result = `EXEC_XLEN'(!equal);
      ALU_LT:   result = `EXEC_XLEN'(lt_signed);
      ALU_GE:   result = `EXEC_XLEN'(!lt_signed);
      ALU_LTU:  result = `EXEC_XLEN'(lt_unsigned);
      ALU_GEU:  result = `EXEC_XLEN'(!lt_unsigned);
      default:  result = a + b;
    endcase
  end

endmodule

// File: rtl/operand_stage.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module operand_stage (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  exec_pkg::issue_t in_issue,
  exec_if.source           out
);
  import exec_pkg::*;

  logic                  full;
  operand_t              held;
  operand_t              next_operand;
  logic [`EXEC_XLEN-1:0] operand_b;

  always_comb begin
    case (in_issue.op2_sel)
      OP2_IMM: operand_b = in_issue.imm;
      OP2_CSR: operand_b = in_issue.csr_val; // CSR read-modify instructions.
      default: operand_b = in_issue.rs2_val;
    endcase
  end

  always_comb begin
    next_operand.alu_op     = in_issue.alu_op;
    next_operand.operand_a  = in_issue.rs1_val;
    next_operand.operand_b  = operand_b;
    next_operand.snpc       = in_issue.pc + `EXEC_XLEN'(`EXEC_ILEN_BYTES);
    next_operand.dnpc       = in_issue.pc + in_issue.imm; // Also the auipc result.
    next_operand.csr_val    = in_issue.csr_val;
    next_operand.npc_sel    = in_issue.npc_sel;
    next_operand.wb_sel     = in_issue.wb_sel;
    next_operand.store_data = in_issue.rs2_val;
  end

  // The register can take a new item when it is empty or is being drained.
  assign in_ready = !full || out.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      held <= next_operand;
    end
  end

  assign out.valid   = full;
  assign out.operand = held;
  assign out.result  = '0; // Not carried on this link.

endmodule

// File: rtl/branch_resolve.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module branch_resolve (
  input  logic   clock,
  input  logic   reset,
  exec_if.sink   up,
  exec_if.source down
);
  import exec_pkg::*;

  operand_t              item;
  result_t               res;
  logic [`EXEC_XLEN-1:0] alu_result;
  logic                  shadow;
  logic                  squash;

  assign item = up.operand;

  alu u_alu (
    .op     (item.alu_op),
    .a      (item.operand_a),
    .b      (item.operand_b),
    .result (alu_result)
  );

  always_comb begin
    case (item.npc_sel)
      NPC_JAL:    res.npc = item.dnpc;
      NPC_JALR:   res.npc = {alu_result[`EXEC_XLEN-1:1], 1'b0};
      NPC_BRANCH: res.npc = alu_result[0] ? item.dnpc : item.snpc;
      NPC_CSR:    res.npc = item.csr_val; // Trap entry and return.
      default:    res.npc = item.snpc;
    endcase

    case (item.wb_sel)
      WB_SNPC: res.wb_data = item.snpc; // Link address.
      WB_DNPC: res.wb_data = item.dnpc;
      WB_CSR:  res.wb_data = item.csr_val;
      default: res.wb_data = alu_result;
    endcase

    res.redirect   = res.npc != item.snpc;
    res.store_data = item.store_data;
  end

  // The instruction behind a redirect was fetched down the wrong path.
  assign squash = shadow && up.valid;

  assign up.ready     = squash || down.ready;
  assign down.valid   = up.valid && !shadow;
  assign down.result  = res;
  assign down.operand = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      shadow <= 1'b0;
    end else if (squash) begin
      shadow <= 1'b0;
    end else if (down.valid && down.ready && res.redirect) begin
      shadow <= 1'b1;
    end
  end

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic              clock,
  input  logic              reset,
  exec_if.sink              in,
  output logic              out_valid,
  input  logic              out_ready,
  output exec_pkg::result_t out_result
);
  import exec_pkg::*;

  logic    full;
  result_t held;

  // Accept when empty or when the held result leaves this cycle.
  assign in.ready = !full || out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in.ready) begin
      full <= in.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in.valid && in.ready) begin
      held <= in.result;
    end
  end

  assign out_valid  = full;
  assign out_result = held; // Stays put while out_ready is low.

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`EXEC_XLEN-1:0] in_pc,
  input  logic [`EXEC_XLEN-1:0] in_rs1_val,
  input  logic [`EXEC_XLEN-1:0] in_rs2_val,
  input  logic [`EXEC_XLEN-1:0] in_imm,
  input  logic [`EXEC_XLEN-1:0] in_csr_val,
  input  exec_pkg::alu_op_t     in_alu_op,
  input  exec_pkg::op2_sel_t    in_op2_sel,
  input  exec_pkg::npc_sel_t    in_npc_sel,
  input  exec_pkg::wb_sel_t     in_wb_sel,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`EXEC_XLEN-1:0] out_wb_data,
  output logic [`EXEC_XLEN-1:0] out_npc,
  output logic                  out_redirect,
  output logic [`EXEC_XLEN-1:0] out_store_data
);
  import exec_pkg::*;

  issue_t  issue;
  result_t result;

  exec_if operand_link ();
  exec_if result_link ();

  always_comb begin
    issue.pc      = in_pc;
    issue.rs1_val = in_rs1_val;
    issue.rs2_val = in_rs2_val;
    issue.imm     = in_imm;
    issue.csr_val = in_csr_val;
    issue.alu_op  = in_alu_op;
    issue.op2_sel = in_op2_sel;
    issue.npc_sel = in_npc_sel;
    issue.wb_sel  = in_wb_sel;
  end

  operand_stage u_operand_stage (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_issue (issue),
    .out      (operand_link.source)
  );

  branch_resolve u_branch_resolve (
    .clock (clock),
    .reset (reset),
    .up    (operand_link.sink),
    .down  (result_link.source)
  );

  result_stage u_result_stage (
    .clock      (clock),
    .reset      (reset),
    .in         (result_link.sink),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (result)
  );

  assign out_wb_data    = result.wb_data;
  assign out_npc        = result.npc;
  assign out_redirect   = result.redirect;
  assign out_store_data = result.store_data;

endmodule

// File: bench/exec_core_properties.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core_properties (
  input logic                  clock,
  input logic                  reset,
  input logic                  in_ready,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic [`EXEC_XLEN-1:0] out_wb_data,
  input logic [`EXEC_XLEN-1:0] out_npc,
  input logic                  out_redirect,
  input logic [`EXEC_XLEN-1:0] out_store_data
);

  logic [3*`EXEC_XLEN:0] payload;

  assign payload = {out_wb_data, out_npc, out_redirect, out_store_data};

  // Both registers are empty one cycle into reset.
  reset_clears_output: assert property (@(posedge clock) reset |=> !out_valid)
    else $error("out_valid was high after a reset cycle");

  reset_opens_input: assert property (@(posedge clock) reset |=> in_ready)
    else $error("in_ready was low after a reset cycle");

  // A stalled result keeps its valid and its whole payload.
  output_held_under_stall: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(payload))
    else $error("output changed while out_ready was low");

endmodule

// File: bench/exec_core_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core_tb;
  import exec_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_ITEMS   = 400;

  logic    clock;
  logic    reset;
  logic    in_valid;
  logic    in_ready;
  issue_t  drive;
  logic    out_valid;
  logic    out_ready;
  result_t observed;
  logic    random_ready;
  logic    squash_next;
  logic    pass_reached;
  logic    fail_shown;
  int      cycle = 0;
  int      received;
  int      expected_total;
  issue_t  issued[$];
  result_t expected[$];

  exec_core DUT (
    .clock          (clock),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_pc          (drive.pc),
    .in_rs1_val     (drive.rs1_val),
    .in_rs2_val     (drive.rs2_val),
    .in_imm         (drive.imm),
    .in_csr_val     (drive.csr_val),
    .in_alu_op      (drive.alu_op),
    .in_op2_sel     (drive.op2_sel),
    .in_npc_sel     (drive.npc_sel),
    .in_wb_sel      (drive.wb_sel),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_wb_data    (observed.wb_data),
    .out_npc        (observed.npc),
    .out_redirect   (observed.redirect),
    .out_store_data (observed.store_data)
  );

  bind exec_core exec_core_properties u_properties (
    .clock          (clock),
    .reset          (reset),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_wb_data    (out_wb_data),
    .out_npc        (out_npc),
    .out_redirect   (out_redirect),
    .out_store_data (out_store_data)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  task automatic stop_with_failure();
    fail_shown = 1'b1;
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_result(result_t actual, result_t want);
    if (actual !== want) begin
      $display("Error at time %0t: result mismatch on output %0d", $time, received);
      $display("  got      wb_data %h npc %h redirect %b store_data %h",
               actual.wb_data, actual.npc, actual.redirect, actual.store_data);
      $display("  expected wb_data %h npc %h redirect %b store_data %h",
               want.wb_data, want.npc, want.redirect, want.store_data);
      stop_with_failure();
    end
  endtask

  task automatic check_count(string what, int actual, int want);
    if (actual != want) begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, actual, want);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string what, logic actual, logic want);
    if (actual !== want) begin
      $display("Error at time %0t: %s is %b, expected %b", $time, what, actual, want);
      stop_with_failure();
    end
  endtask

  // Expected outcome of one instruction, straight from the execute rules.
  function automatic result_t expected_result(issue_t it);
    word_t   a;
    word_t   b;
    word_t   alu_out;
    word_t   snpc;
    word_t   dnpc;
    result_t r;
    a    = it.rs1_val;
    b    = (it.op2_sel == OP2_IMM) ? it.imm : (it.op2_sel == OP2_CSR) ? it.csr_val : it.rs2_val;
    snpc = it.pc + word_t'(`EXEC_ILEN_BYTES);
    dnpc = it.pc + it.imm;
    case (it.alu_op)
      ALU_ADD:           alu_out = a + b;
      ALU_SUB:           alu_out = a - b;
      ALU_AND:           alu_out = a & b;
      ALU_OR:            alu_out = a | b;
      ALU_XOR:           alu_out = a ^ b;
      ALU_SLL:           alu_out = a << (b % `EXEC_XLEN);
      ALU_SRL:           alu_out = a >> (b % `EXEC_XLEN);
      ALU_SRA:           alu_out = $signed(a) >>> (b % `EXEC_XLEN);
      ALU_SLT, ALU_LT:   alu_out = word_t'($signed(a) < $signed(b));
      ALU_SLTU, ALU_LTU: alu_out = word_t'(a < b);
      ALU_EQ:            alu_out = word_t'(a == b);
      ALU_NE:            alu_out = word_t'(a != b);
      ALU_GE:            alu_out = word_t'($signed(a) >= $signed(b));
      ALU_GEU:           alu_out = word_t'(a >= b);
    endcase
    case (it.npc_sel)
      NPC_JAL:    r.npc = dnpc;
      NPC_JALR:   r.npc = alu_out & ~word_t'(1);
      NPC_BRANCH: r.npc = alu_out[0] ? dnpc : snpc;
      NPC_CSR:    r.npc = it.csr_val;
      default:    r.npc = snpc;
    endcase
    case (it.wb_sel)
      WB_SNPC: r.wb_data = snpc;
      WB_DNPC: r.wb_data = dnpc;
      WB_CSR:  r.wb_data = it.csr_val;
      default: r.wb_data = alu_out;
    endcase
    r.redirect   = r.npc != snpc;
    r.store_data = it.rs2_val;
    return r;
  endfunction

  function automatic issue_t random_issue();
    issue_t it;
    it.pc      = $urandom & 32'hffff_fffc;
    it.rs1_val = $urandom;
    it.rs2_val = (($urandom % 4) == 0) ? it.rs1_val : $urandom; // Equal operands now and then.
    it.imm     = $urandom;
    it.csr_val = $urandom & 32'hffff_fffc;
    it.alu_op  = alu_op_t'(4'($urandom));
    it.op2_sel = op2_sel_t'(2'($urandom % 3));
    it.npc_sel = (($urandom % 2) == 0) ? NPC_SEQ : npc_sel_t'(3'($urandom % 5));
    it.wb_sel  = wb_sel_t'(2'($urandom));
    return it;
  endfunction

  task automatic send(issue_t it);
    int waited;
    @(negedge clock);
    drive    = it;
    in_valid = 1'b1;
    waited   = 0;
    @(posedge clock);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("Timed out waiting for the DUT to accept an instruction.");
        stop_with_failure();
      end
      @(posedge clock);
    end
  endtask

  // Issued instructions are walked in order; the one after a redirect is dropped.
  always @(posedge clock) begin : model
    issue_t  it;
    result_t want;
    if (reset) begin
      squash_next = 1'b0;
    end else if (in_valid && in_ready) begin
      issued.push_back(drive);
    end
    while (issued.size() > 0) begin
      it = issued.pop_front();
      if (squash_next) begin
        squash_next = 1'b0;
      end else begin
        want = expected_result(it);
        expected.push_back(want);
        expected_total++;
        squash_next = want.redirect;
      end
    end
  end

  always @(posedge clock) begin
    if (!reset && out_valid && out_ready) begin
      if (expected.size() > 0) begin
        check_result(observed, expected.pop_front());
      end
      received++; // Extra results are caught by the final count.
    end
  end

  always @(negedge clock) begin
    if (random_ready) out_ready = ($urandom % 4) != 0;
  end

  initial begin
    issue_t item;
    int     start;
    int     waited;
    void'($urandom(32'h49dc));
    reset          = 1'b1;
    in_valid       = 1'b0;
    drive          = '0;
    out_ready      = 1'b1;
    random_ready   = 1'b0;
    squash_next    = 1'b0;
    pass_reached   = 1'b0;
    fail_shown     = 1'b0;
    received       = 0;
    expected_total = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_flag("out_valid after reset", out_valid, 1'b0);
    check_flag("in_ready after reset", in_ready, 1'b1);

    for (int i = 0; i < 4; i++) begin
      item         = random_issue();
      item.npc_sel = NPC_SEQ; // No redirect, so nothing is squashed.
      send(item);
      start = cycle;
      @(negedge clock);
      in_valid = 1'b0;
      waited   = 0;
      @(posedge clock);
      while (!out_valid) begin
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          $display("Timed out waiting for out_valid in the latency test.");
          stop_with_failure();
        end
        @(posedge clock);
      end
      check_count("input to output latency", cycle - start, 2);
    end

    random_ready = 1'b1;
    for (int i = 0; i < RANDOM_ITEMS; i++) begin
      send(random_issue());
      if (($urandom % 4) == 0) begin
        @(negedge clock);
        in_valid = 1'b0;
      end
    end
    @(negedge clock);
    in_valid = 1'b0;

    waited = 0;
    while (expected.size() > 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("Timed out waiting for the remaining results to drain.");
        stop_with_failure();
      end
      @(posedge clock);
    end
    @(negedge clock);
    random_ready = 1'b0;
    out_ready    = 1'b1;
    repeat (8) @(posedge clock); // Any extra output would show up here.
    check_count("number of results", received, expected_total);

    pass_reached = 1'b1;
    $display("All tests passed");
    $finish;
  end

  final begin
    if (!pass_reached && !fail_shown) $display("Some tests failed");
  end

endmodule

// File: exec_core.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_if.sv
rtl/alu.sv
rtl/operand_stage.sv
rtl/branch_resolve.sv
rtl/result_stage.sv
rtl/exec_core.sv
bench/exec_core_properties.sv
bench/exec_core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the exec_core testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module exec_core_tb \
  -f exec_core.f \
  --Mdir obj_dir -o exec_core_sim

./obj_dir/exec_core_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi
